/* logic/wb_pkg.sv */
package wb_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    // stall vector bits: fetch, decode, execute, memory, writeback
    localparam int STAGE_N    = 5;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // load size codes
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [INST_W-1:0] EBREAK_WORD = {12'h001, 13'h0, OPC_SYSTEM};

    // instruction word, seen whole or as i-type fields
    typedef union packed {
        logic [INST_W-1:0] raw;
        struct packed {
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } itype;
    } inst_u;

endpackage

/* logic/mem_access.sv */
module mem_access
    import wb_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [STAGE_N-1:0]    stall_vec,
    input  logic                  ex_valid_i,
    input  logic [XLEN-1:0]       ex_pc_i,
    input  logic [INST_W-1:0]     ex_inst_i,
    input  logic [XLEN-1:0]       ex_result_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
    input  logic                  ex_rd_ena_i,
    input  logic [31:0]           dmem_rdata_i,
    input  logic                  dmem_ack_i,
    output logic                  dmem_req_o,
    output logic [XLEN-1:0]       dmem_addr_o,
    output logic                  mem_busy_o,
    output logic [XLEN-1:0]       mem_pc_o,
    output logic [INST_W-1:0]     mem_inst_o,
    output logic [XLEN-1:0]       mem_rd_data_o,
    output logic [REG_ADDR_W-1:0] mem_rd_addr_o,
    output logic                  mem_rd_ena_o
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_REQ   = 2'd1;
    localparam logic [1:0] ST_ACKLO = 2'd2;

    logic [1:0]            state;
    logic                  mem_valid;
    logic                  load_done;
    logic [XLEN-1:0]       mem_pc;
    inst_u                 mem_inst;
    logic [XLEN-1:0]       mem_result;
    logic [REG_ADDR_W-1:0] mem_rd_addr;
    logic                  mem_rd_ena;
    logic [31:0]           ld_word;
    logic [31:0]           ld_shift;
    logic [XLEN-1:0]       ld_val;
    logic                  advance;
    logic                  is_load;
    logic                  ack_low_seen;
    logic                  present;

    assign advance      = ~stall_vec[3];
    assign is_load      = mem_inst.itype.opcode == OPC_LOAD;
    assign ack_low_seen = (state == ST_ACKLO) && !dmem_ack_i;
    // busy from capture until the cycle ack is seen low again
    assign mem_busy_o   = mem_valid && is_load && !load_done && !ack_low_seen;
    assign present      = mem_valid && !mem_busy_o && advance;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_valid <= 1'b0;
        end else if (advance) begin
            mem_valid <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mem_pc      <= ex_pc_i;
            mem_inst    <= ex_inst_i;
            mem_result  <= ex_result_i;
            mem_rd_addr <= ex_rd_addr_i;
            mem_rd_ena  <= ex_rd_ena_i;
        end
    end

    // handshake finished while the stage is held, don't ask again
    always_ff @(posedge clk) begin
        if (rst_i || advance) begin
            load_done <= 1'b0;
        end else if (ack_low_seen) begin
            load_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (mem_valid && is_load && !load_done && !dmem_ack_i) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (dmem_ack_i) begin
                        state <= ST_ACKLO;
                    end
                end
                default: begin
                    if (!dmem_ack_i) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_REQ && dmem_ack_i) begin
            ld_word <= dmem_rdata_i;
        end
    end

    assign dmem_req_o  = state == ST_REQ;
    assign dmem_addr_o = {mem_result[XLEN-1:2], 2'b00};

    // byte lane picked by the low address bits
    assign ld_shift = ld_word >> {mem_result[1:0], 3'b000};

    always_comb begin
        case (mem_inst.itype.funct3)
            F3_LB:   ld_val = XLEN'($signed(ld_shift[7:0]));
            F3_LBU:  ld_val = XLEN'(ld_shift[7:0]);
            F3_LH:   ld_val = XLEN'($signed(ld_shift[15:0]));
            F3_LHU:  ld_val = XLEN'(ld_shift[15:0]);
            default: ld_val = XLEN'($signed(ld_word));
        endcase
    end

    // bubble downstream while busy or held
    assign mem_pc_o      = present ? mem_pc : '0;
    assign mem_inst_o    = present ? mem_inst.raw : '0;
    assign mem_rd_data_o = is_load ? ld_val : mem_result;
    assign mem_rd_addr_o = mem_rd_addr;
    assign mem_rd_ena_o  = present && mem_rd_ena;

endmodule

/* logic/stall_ctrl.sv */
module stall_ctrl
    import wb_pkg::*;
(
    input  logic               clk,
    input  logic               rst_i,
    input  logic               mem_busy_i,
    input  logic               halt_i,
    output logic [STAGE_N-1:0] stall_vec_o
);

    logic halt_q;

    // halt registered so all stages see it on the same edge
    always_ff @(posedge clk) begin
        if (rst_i) begin
            halt_q <= 1'b0;
        end else begin
            halt_q <= halt_i;
        end
    end

    always_comb begin
        if (halt_q) begin
            // freeze everything, writeback flushes
            stall_vec_o = '1;
        end else if (mem_busy_i) begin
            // front stages wait, writeback takes a bubble
            stall_vec_o = {1'b0, {(STAGE_N-1){1'b1}}};
        end else begin
            stall_vec_o = '0;
        end
    end

endmodule

/* logic/mem_wb.sv */
module mem_wb
    import wb_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [STAGE_N-1:0]    stall_vec_i,
    input  logic [XLEN-1:0]       mem_pc_i,
    input  logic [INST_W-1:0]     mem_inst_i,
    input  logic [XLEN-1:0]       mem_rd_data_i,
    input  logic [REG_ADDR_W-1:0] mem_rd_addr_i,
    input  logic                  mem_rd_ena_i,
    output logic [XLEN-1:0]       wb_pc_o,
    output logic [INST_W-1:0]     wb_inst_o,
    output logic [XLEN-1:0]       wb_rd_data_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic                  wb_rd_ena_o
);

    logic wb_hold;
    logic wb_flush;

    assign wb_hold  = stall_vec_i[STAGE_N-1];
    // full freeze clears the entry after it has been written once
    assign wb_flush = &stall_vec_i;

    always_ff @(posedge clk) begin
        if (rst_i || wb_flush) begin
            wb_rd_ena_o <= 1'b0;
            wb_inst_o   <= '0;
        end else if (!wb_hold) begin
            wb_rd_ena_o <= mem_rd_ena_i;
            wb_inst_o   <= mem_inst_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!wb_hold) begin
            wb_pc_o      <= mem_pc_i;
            wb_rd_data_o <= mem_rd_data_i;
            wb_rd_addr_o <= mem_rd_addr_i;
        end
    end

endmodule

/* logic/regfile.sv */
module regfile
    import wb_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr_i,
    output logic [XLEN-1:0]       rdata_o,
    output logic [XLEN-1:0]       a0_o
);

    localparam int                    REG_N   = 1 << REG_ADDR_W;
    localparam logic [REG_ADDR_W-1:0] A0_ADDR = REG_ADDR_W'(10);

    logic [XLEN-1:0] regs [REG_N];
    logic            wr_live;

    // x0 never written
    assign wr_live = we_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-first bypass on both read paths
    always_comb begin
        if (raddr_i == '0) begin
            rdata_o = '0;
        end else if (wr_live && waddr_i == raddr_i) begin
            rdata_o = wdata_i;
        end else begin
            rdata_o = regs[raddr_i];
        end
    end

    assign a0_o = (wr_live && waddr_i == A0_ADDR) ? wdata_i : regs[A0_ADDR];

endmodule

/* logic/commit_monitor.sv */
module commit_monitor
    import wb_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic [XLEN-1:0]   wb_pc_i,
    input  logic [INST_W-1:0] wb_inst_i,
    input  logic [XLEN-1:0]   a0_i,
    output logic              commit_valid_o,
    output logic [XLEN-1:0]   commit_pc_o,
    output logic              trap_o,
    output logic [XLEN-1:0]   trap_code_o
);

    inst_u wb_word;
    logic  is_ebreak;

    assign wb_word.raw = wb_inst_i;
    assign is_ebreak   = wb_word.raw == EBREAK_WORD;

    // zero word is a bubble, anything else retired
    always_ff @(posedge clk) begin
        if (rst_i) begin
            commit_valid_o <= 1'b0;
            trap_o         <= 1'b0;
            trap_code_o    <= '0;
        end else begin
            commit_valid_o <= wb_word.raw != '0;
            trap_o         <= is_ebreak;
            // exit code lives in a0
            trap_code_o    <= is_ebreak ? a0_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        commit_pc_o <= wb_pc_i;
    end

endmodule

/* logic/wb_tail_top.sv */
module wb_tail_top
    import wb_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  ex_valid_i,
    input  logic [XLEN-1:0]       ex_pc_i,
    input  logic [INST_W-1:0]     ex_inst_i,
    input  logic [XLEN-1:0]       ex_result_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
    input  logic                  ex_rd_ena_i,
    output logic                  ex_stall_o,
    output logic                  dmem_req_o,
    output logic [XLEN-1:0]       dmem_addr_o,
    input  logic [31:0]           dmem_rdata_i,
    input  logic                  dmem_ack_i,
    input  logic                  halt_i,
    input  logic [REG_ADDR_W-1:0] rf_raddr_i,
    output logic [XLEN-1:0]       rf_rdata_o,
    output logic                  commit_valid_o,
    output logic [XLEN-1:0]       commit_pc_o,
    output logic                  trap_o,
    output logic [XLEN-1:0]       trap_code_o
);

    logic [STAGE_N-1:0]    stall_vec;
    logic                  mem_busy;
    logic [XLEN-1:0]       mem_pc;
    logic [INST_W-1:0]     mem_inst;
    logic [XLEN-1:0]       mem_rd_data;
    logic [REG_ADDR_W-1:0] mem_rd_addr;
    logic                  mem_rd_ena;
    logic [XLEN-1:0]       wb_pc;
    logic [INST_W-1:0]     wb_inst;
    logic [XLEN-1:0]       wb_rd_data;
    logic [REG_ADDR_W-1:0] wb_rd_addr;
    logic                  wb_rd_ena;
    logic [XLEN-1:0]       a0_value;

    // execute stage bit
    assign ex_stall_o = stall_vec[2];

    mem_access #(.XLEN(XLEN)) u_mem_access (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_vec     (stall_vec),
        .ex_valid_i    (ex_valid_i),
        .ex_pc_i       (ex_pc_i),
        .ex_inst_i     (ex_inst_i),
        .ex_result_i   (ex_result_i),
        .ex_rd_addr_i  (ex_rd_addr_i),
        .ex_rd_ena_i   (ex_rd_ena_i),
        .dmem_rdata_i  (dmem_rdata_i),
        .dmem_ack_i    (dmem_ack_i),
        .dmem_req_o    (dmem_req_o),
        .dmem_addr_o   (dmem_addr_o),
        .mem_busy_o    (mem_busy),
        .mem_pc_o      (mem_pc),
        .mem_inst_o    (mem_inst),
        .mem_rd_data_o (mem_rd_data),
        .mem_rd_addr_o (mem_rd_addr),
        .mem_rd_ena_o  (mem_rd_ena)
    );

    stall_ctrl u_stall_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .mem_busy_i  (mem_busy),
        .halt_i      (halt_i),
        .stall_vec_o (stall_vec)
    );

    mem_wb #(.XLEN(XLEN)) u_mem_wb (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_vec_i   (stall_vec),
        .mem_pc_i      (mem_pc),
        .mem_inst_i    (mem_inst),
        .mem_rd_data_i (mem_rd_data),
        .mem_rd_addr_i (mem_rd_addr),
        .mem_rd_ena_i  (mem_rd_ena),
        .wb_pc_o       (wb_pc),
        .wb_inst_o     (wb_inst),
        .wb_rd_data_o  (wb_rd_data),
        .wb_rd_addr_o  (wb_rd_addr),
        .wb_rd_ena_o   (wb_rd_ena)
    );

    regfile #(.XLEN(XLEN)) u_regfile (
        .clk     (clk),
        .rst_i   (rst_i),
        .we_i    (wb_rd_ena),
        .waddr_i (wb_rd_addr),
        .wdata_i (wb_rd_data),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o),
        .a0_o    (a0_value)
    );

    commit_monitor #(.XLEN(XLEN)) u_commit_monitor (
        .clk            (clk),
        .rst_i          (rst_i),
        .wb_pc_i        (wb_pc),
        .wb_inst_i      (wb_inst),
        .a0_i           (a0_value),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .trap_o         (trap_o),
        .trap_code_o    (trap_code_o)
    );

endmodule

/* verif/wb_tail_checker.sv */
module wb_tail_checker
    import wb_pkg::*;
(
    input logic               clk,
    input logic               rst_i,
    input logic               req_i,
    input logic               ack_i,
    input logic               busy_i,
    input logic               halt_i,
    input logic [STAGE_N-1:0] stall_vec_i
);

    // new request only once ack was seen low
    req_rise_ack_low: assert property (
        @(posedge clk) disable iff (rst_i) $rose(req_i) |-> !$past(ack_i)
    ) else $error("dmem request rose while ack was still high");

    // request stays up until the memory answers
    req_hold_until_ack: assert property (
        @(posedge clk) disable iff (rst_i) (req_i && !ack_i) |=> req_i
    ) else $error("dmem request dropped before ack");

    // halt seen one edge earlier is the registered halt
    busy_stalls_ex: assert property (
        @(posedge clk) disable iff (rst_i) (busy_i || $past(halt_i)) |-> stall_vec_i[2]
    ) else $error("execute stage not stalled while memory busy or halted");

    halt_freezes_all: assert property (
        @(posedge clk) disable iff (rst_i) $past(halt_i) |-> (&stall_vec_i)
    ) else $error("halt from the previous cycle did not freeze every stage");

endmodule

/* verif/wb_tail_tb.sv */
module wb_tail_tb;
    import wb_pkg::*;

    localparam int          XLEN         = 32;
    localparam int          CLK_PERIOD   = 8;
    localparam int          DRIVE_DLY    = 1;
    localparam int          RESET_CYCLES = 16;
    localparam int          TIMEOUT      = 200;
    localparam int          ROUNDS       = 8;
    localparam int          ROUND_LEN    = 24;
    localparam logic [31:0] SEED         = 32'hf9736f86;
    localparam logic [31:0] MEM_BASE     = 32'h0000_1000;

    logic                  clk;
    logic                  rst_i;
    logic                  ex_valid_i;
    logic [XLEN-1:0]       ex_pc_i;
    logic [INST_W-1:0]     ex_inst_i;
    logic [XLEN-1:0]       ex_result_i;
    logic [REG_ADDR_W-1:0] ex_rd_addr_i;
    logic                  ex_rd_ena_i;
    logic                  ex_stall_o;
    logic                  dmem_req_o;
    logic [XLEN-1:0]       dmem_addr_o;
    logic [31:0]           dmem_rdata_i;
    logic                  dmem_ack_i;
    logic                  halt_i;
    logic [REG_ADDR_W-1:0] rf_raddr_i;
    logic [XLEN-1:0]       rf_rdata_o;
    logic                  commit_valid_o;
    logic [XLEN-1:0]       commit_pc_o;
    logic                  trap_o;
    logic [XLEN-1:0]       trap_code_o;

    // sparse data memory keyed by word address
    logic [31:0]     mem_words [logic [31:0]];
    logic [XLEN-1:0] shadow [32];
    logic [XLEN-1:0] exp_pc_q [$];
    logic            exp_trap_q [$];
    logic [XLEN-1:0] exp_code_q [$];
    logic [XLEN-1:0] next_pc;
    logic            halts_on;

    wb_tail_top #(.XLEN(XLEN)) u_dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .ex_valid_i     (ex_valid_i),
        .ex_pc_i        (ex_pc_i),
        .ex_inst_i      (ex_inst_i),
        .ex_result_i    (ex_result_i),
        .ex_rd_addr_i   (ex_rd_addr_i),
        .ex_rd_ena_i    (ex_rd_ena_i),
        .ex_stall_o     (ex_stall_o),
        .dmem_req_o     (dmem_req_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_rdata_i   (dmem_rdata_i),
        .dmem_ack_i     (dmem_ack_i),
        .halt_i         (halt_i),
        .rf_raddr_i     (rf_raddr_i),
        .rf_rdata_o     (rf_rdata_o),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .trap_o         (trap_o),
        .trap_code_o    (trap_code_o)
    );

    bind mem_access wb_tail_checker u_handshake_chk (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (dmem_req_o),
        .ack_i       (dmem_ack_i),
        .busy_i      (mem_busy_o),
        .halt_i      (1'b0),
        .stall_vec_i (stall_vec)
    );

    bind stall_ctrl wb_tail_checker u_stall_chk (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (1'b0),
        .ack_i       (1'b0),
        .busy_i      (1'b0),
        .halt_i      (halt_i),
        .stall_vec_i (stall_vec_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (exp !== act) begin
            stop_with_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // unwritten words get a pattern built from the full address
    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        logic [31:0] waddr;
        waddr = {addr[31:2], 2'b00};
        if (mem_words.exists(waddr)) begin
            return mem_words[waddr];
        end
        return waddr ^ {waddr[15:0], waddr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [XLEN-1:0] load_value(input logic [31:0] word,
                                                   input logic [1:0] off,
                                                   input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            F3_LB:   return {{24{b[7]}}, b};
            F3_LBU:  return {24'h0, b};
            F3_LH:   return {{16{h[15]}}, h};
            F3_LHU:  return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // model updated at issue while the inputs wait for the stage
    task automatic issue(input logic [31:0] inst, input logic [XLEN-1:0] result,
                         input logic [4:0] rd, input logic rd_ena,
                         input logic [XLEN-1:0] wb_value, input logic is_ebreak);
        int waited;
        exp_pc_q.push_back(next_pc);
        exp_trap_q.push_back(is_ebreak);
        exp_code_q.push_back(shadow[10]);
        if (rd_ena && rd != 5'd0) begin
            shadow[rd] = wb_value;
        end
        ex_valid_i   = 1'b1;
        ex_pc_i      = next_pc;
        ex_inst_i    = inst;
        ex_result_i  = result;
        ex_rd_addr_i = rd;
        ex_rd_ena_i  = rd_ena;
        waited = 0;
        @(negedge clk);
        while (ex_stall_o) begin
            if (waited == TIMEOUT) begin
                stop_with_error("timeout: execute stage stayed stalled");
            end
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        ex_valid_i = 1'b0;
        next_pc += 4;
    endtask

    task automatic issue_alu(input logic [4:0] rd, input logic rd_ena);
        logic [31:0]     inst;
        logic [XLEN-1:0] result;
        result = $urandom;
        inst   = {12'($urandom), 5'($urandom), 3'b000, rd, 7'b0010011};
        issue(inst, result, rd, rd_ena, result, 1'b0);
    endtask

    task automatic issue_load(input logic [4:0] rd);
        logic [2:0]  f3;
        logic [1:0]  off;
        logic [31:0] addr;
        logic [31:0] inst;
        case ($urandom_range(0, 4))
            0:       f3 = F3_LB;
            1:       f3 = F3_LH;
            2:       f3 = F3_LW;
            3:       f3 = F3_LBU;
            default: f3 = F3_LHU;
        endcase
        // halves and words stay naturally aligned
        case (f3)
            F3_LW:         off = 2'b00;
            F3_LH, F3_LHU: off = {1'($urandom), 1'b0};
            default:       off = 2'($urandom);
        endcase
        addr = MEM_BASE + ($urandom_range(0, 31) << 2) + off;
        inst = {12'($urandom), 5'd2, f3, rd, OPC_LOAD};
        issue(inst, addr, rd, 1'b1, load_value(mem_read(addr), off, f3), 1'b0);
    endtask

    task automatic issue_random();
        logic [4:0] rd;
        rd = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
        if ($urandom_range(0, 9) < 4) begin
            issue_load(rd);
        end else begin
            issue_alu(rd, $urandom_range(0, 5) != 0);
        end
        if ($urandom_range(0, 3) == 0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic respond_dmem();
        int delay;
        int waited;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (dmem_req_o && !dmem_ack_i) begin
                check_value("dmem_addr_align", '0, XLEN'(dmem_addr_o[1:0]));
                delay = $urandom_range(0, 5);
                repeat (delay) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
                dmem_rdata_i = mem_read(dmem_addr_o);
                dmem_ack_i   = 1'b1;
                waited = 0;
                while (dmem_req_o) begin
                    if (waited == TIMEOUT) begin
                        stop_with_error("timeout: request not dropped after ack");
                    end
                    @(posedge clk);
                    #DRIVE_DLY;
                    waited++;
                end
                dmem_ack_i = 1'b0;
            end
        end
    endtask

    task automatic drive_halts();
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (halts_on && $urandom_range(0, 15) == 0) begin
                halt_i = 1'b1;
                repeat ($urandom_range(1, 4)) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
                halt_i = 1'b0;
            end
        end
    endtask

    task automatic watch_commits();
        logic [XLEN-1:0] exp_code;
        logic            exp_trap;
        forever begin
            @(negedge clk);
            if (rf_raddr_i == '0) begin
                check_value("x0_read", '0, rf_rdata_o);
            end
            if (commit_valid_o) begin
                if (exp_pc_q.size() == 0) begin
                    stop_with_error("commit seen with no instruction left to retire");
                end
                check_value("commit_pc", exp_pc_q.pop_front(), commit_pc_o);
                exp_trap = exp_trap_q.pop_front();
                exp_code = exp_code_q.pop_front();
                check_value("trap_flag", XLEN'(exp_trap), XLEN'(trap_o));
                if (exp_trap) begin
                    check_value("trap_code", exp_code, trap_code_o);
                end
            end else if (trap_o) begin
                stop_with_error("trap raised without a commit");
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_pc_q.size() != 0) begin
            if (waited == TIMEOUT) begin
                stop_with_error("timeout: issued instructions did not retire");
            end
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
    endtask

    task automatic compare_regs(input string tag);
        for (int i = 0; i < 32; i++) begin
            rf_raddr_i = 5'(i);
            @(negedge clk);
            check_value($sformatf("%s_x%0d", tag, i), shadow[i], rf_rdata_o);
            @(posedge clk);
            #DRIVE_DLY;
        end
        rf_raddr_i = '0;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_i        = 1'b1;
        ex_valid_i   = 1'b0;
        ex_pc_i      = '0;
        ex_inst_i    = '0;
        ex_result_i  = '0;
        ex_rd_addr_i = '0;
        ex_rd_ena_i  = 1'b0;
        dmem_rdata_i = '0;
        dmem_ack_i   = 1'b0;
        halt_i       = 1'b0;
        rf_raddr_i   = '0;
        halts_on     = 1'b0;
        next_pc      = 32'h8000_0000;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        // every other word stored and the rest from the fill pattern
        for (int i = 0; i < 16; i++) begin
            mem_words[MEM_BASE + (i << 3)] = $urandom;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_i = 1'b0;
        @(negedge clk);
        check_value("reset_ex_stall", '0, XLEN'(ex_stall_o));
        check_value("reset_dmem_req", '0, XLEN'(dmem_req_o));
        check_value("reset_commit", '0, XLEN'(commit_valid_o));
        check_value("reset_trap", '0, XLEN'(trap_o));
        @(posedge clk);
        #DRIVE_DLY;
        fork
            respond_dmem();
            drive_halts();
            watch_commits();
        join_none
        halts_on = 1'b1;
        for (int r = 0; r < ROUNDS; r++) begin
            for (int k = 0; k < ROUND_LEN; k++) begin
                issue_random();
            end
            drain();
            compare_regs("round_regs");
        end
        halts_on = 1'b0;
        // exit code in a0 before the final ebreak
        issue_alu(5'd10, 1'b1);
        issue(EBREAK_WORD, '0, 5'd0, 1'b0, '0, 1'b1);
        drain();
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        compare_regs("final_regs");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* sources.f */
logic/wb_pkg.sv
logic/mem_access.sv
logic/stall_ctrl.sv
logic/mem_wb.sv
logic/regfile.sv
logic/commit_monitor.sv
logic/wb_tail_top.sv
verif/wb_tail_checker.sv
verif/wb_tail_tb.sv

/* Bender.yml */
package:
  name: wb_tail

sources:
  - logic/wb_pkg.sv
  - logic/mem_access.sv
  - logic/stall_ctrl.sv
  - logic/mem_wb.sv
  - logic/regfile.sv
  - logic/commit_monitor.sv
  - logic/wb_tail_top.sv
  - target: simulation
    files:
      - verif/wb_tail_checker.sv
      - verif/wb_tail_tb.sv
